//--- common/board_ctrl_pkg.sv
// shared types for the SPI board controller
// register map, width typedefs and the structs passed between blocks
package board_ctrl_pkg;

  // register address field of an SPI frame
  // only the first three codes are mapped, the rest are ignored by the bank
  typedef enum logic [3:0] {
    REG_LED_DATA  = 4'd0,
    REG_LED_MODE  = 4'd1,
    REG_ADC_ROUTE = 4'd2
  } reg_addr_t;

  // one register data word
  typedef logic [7:0] reg_data_t;

  // one bit per LED on the board
  typedef logic [7:0] led_vec_t;

  // bits in one write frame
  // 4 address bits, 4 don't-care bits, 8 data bits, MSB first
  localparam int FRAME_BITS = 16;

  // payload of a committed frame, 12 bits
  typedef struct packed {
    reg_addr_t addr;
    reg_data_t data;
  } wr_cmd_t;

  // register contents seen by the I/O driver, 10 bits
  // only bit 0 of the mode and route registers reaches the driver
  typedef struct packed {
    reg_data_t led_data;
    // 1 selects the Gray blink pattern on the LEDs
    logic      blink_en;
    // 1 routes the synchronized sclk to the ADC clock pin
    logic      adc_route_en;
  } ctrl_regs_t;

endpackage

//--- spi_slave/spi_frame_receiver.sv
// write-only SPI mode 0 frame receiver, sampled in the clk domain
// emits one wr_cmd_t with a single-cycle strobe per valid 16-bit frame
`timescale 1ns/1ps

module spi_frame_receiver
  import board_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    sclk,
  input  logic    cs_n,
  input  logic    mosi,
  output wr_cmd_t cmd,
  output logic    wr_strobe,
  output logic    sclk_sync
);

  localparam int ADDR_W = $bits(reg_addr_t);
  localparam int DATA_W = $bits(reg_data_t);
  // counter holds 0 .. FRAME_BITS+1, the top value means "too long"
  localparam int CNT_W = $clog2(FRAME_BITS + 2);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FRAME_BITS);
  localparam logic [CNT_W-1:0] CNT_SAT = CNT_W'(FRAME_BITS + 1);

  // two-flop synchronizers, index 1 is the usable output
  logic [1:0] sclk_ff;
  logic [1:0] cs_ff;
  logic [1:0] mosi_ff;

  // previous synchronized levels, aligned with the edge pulses
  logic sclk_d;
  logic cs_d;
  logic mosi_d;

  // registered edge pulses
  logic sclk_rise;
  logic cs_fall;
  logic cs_rise;

  logic [FRAME_BITS-1:0] shift_q;
  logic [CNT_W-1:0]      bit_cnt;
  logic                  shift_en;

  // pins are asynchronous to clk
  // cs_n resets high so that leaving reset does not look like a frame start
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_ff <= 2'b00;
      cs_ff   <= 2'b11;
      mosi_ff <= 2'b00;
    end
    else
    begin
      sclk_ff <= {sclk_ff[0], sclk};
      cs_ff   <= {cs_ff[0], cs_n};
      mosi_ff <= {mosi_ff[0], mosi};
    end
  end

  assign sclk_sync = sclk_ff[1];

  // edge detect stage
  // the pulses and the delayed levels change on the same edge,
  // so mosi_d is the data bit that goes with sclk_rise
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_d    <= 1'b0;
      cs_d      <= 1'b1;
      mosi_d    <= 1'b0;
      sclk_rise <= 1'b0;
      cs_fall   <= 1'b0;
      cs_rise   <= 1'b0;
    end
    else
    begin
      sclk_d    <= sclk_ff[1];
      cs_d      <= cs_ff[1];
      mosi_d    <= mosi_ff[1];
      sclk_rise <= sclk_ff[1] & ~sclk_d;
      cs_fall   <= ~cs_ff[1] & cs_d;
      cs_rise   <= cs_ff[1] & ~cs_d;
    end
  end

  // mode 0: data is stable on the rising sclk edge, only while selected
  assign shift_en = sclk_rise & ~cs_d;

  // bit counter saturates one above a full frame
  // so any over-long frame stays distinguishable from a good one
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
    end
    else if (cs_fall)
    begin
      bit_cnt <= '0;
    end
    else if (shift_en && bit_cnt != CNT_SAT)
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // MSB first, the oldest bit ends up at the top
  always_ff @(posedge clk)
  begin
    if (shift_en)
    begin
      shift_q <= {shift_q[FRAME_BITS-2:0], mosi_d};
    end
  end

  // commit on cs_n rising
  // strobe only for an exact-length frame, everything else is dropped
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_strobe <= 1'b0;
    end
    else
    begin
      wr_strobe <= cs_rise && (bit_cnt == CNT_FULL);
    end
  end

  // address sits in the first 4 bits, data in the last 8
  // the 4 bits between them are don't-care
  always_ff @(posedge clk)
  begin
    if (cs_rise)
    begin
      cmd.addr <= reg_addr_t'(shift_q[FRAME_BITS-1 -: ADDR_W]);
      cmd.data <= shift_q[DATA_W-1:0];
    end
  end

endmodule

//--- src/ctrl_reg_bank.sv
// control register bank, written by strobed commands from the SPI receiver
// presents the register bits the I/O driver needs as one struct
`timescale 1ns/1ps

module ctrl_reg_bank
  import board_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  wr_cmd_t    cmd,
  input  logic       wr_strobe,
  output ctrl_regs_t regs
);

  // full 8-bit registers as seen by the host
  reg_data_t led_data_q;
  reg_data_t led_mode_q;
  reg_data_t adc_route_q;

  // one write per strobe, no back-pressure
  // the written value appears on regs the cycle after the strobe
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      led_data_q  <= '0;
      led_mode_q  <= '0;
      adc_route_q <= '0;
    end
    else if (wr_strobe)
    begin
      case (cmd.addr)
        REG_LED_DATA:
        begin
          led_data_q <= cmd.data;
        end
        REG_LED_MODE:
        begin
          led_mode_q <= cmd.data;
        end
        REG_ADC_ROUTE:
        begin
          adc_route_q <= cmd.data;
        end
        default:
        begin
          // unmapped address, leave every register alone
        end
      endcase
    end
  end

  // only bit 0 of mode and route means anything to the driver
  // upper bits are kept so the host sees plain 8-bit registers
  assign regs.led_data     = led_data_q;
  assign regs.blink_en     = led_mode_q[0];
  assign regs.adc_route_en = adc_route_q[0];

endmodule

//--- src/board_io_driver.sv
// drives the board LEDs and the ADC clock pin from the control registers
// LEDs show either static data or a Gray-coded blink pattern
`timescale 1ns/1ps

module board_io_driver
  import board_ctrl_pkg::*;
#(
  // prescaler bits below the visible blink pattern
  parameter int unsigned LOG2DELAY = 19
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  ctrl_regs_t regs,
  input  logic       sclk_sync,
  output led_vec_t   led,
  output logic       adc_sclk
);

  localparam int unsigned LED_W = $bits(led_vec_t);
  localparam int unsigned CNT_W = LED_W + LOG2DELAY;

  // free-running blink counter, top LED_W bits are the pattern
  logic [CNT_W-1:0] blink_cnt;
  led_vec_t         blink_top;
  led_vec_t         blink_gray;
  led_vec_t         led_next;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      blink_cnt <= '0;
    end
    else
    begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

  assign blink_top = blink_cnt[CNT_W-1 -: LED_W];

  // binary to Gray, adjacent counts differ in one LED only
  assign blink_gray = blink_top ^ (blink_top >> 1);

  // static data unless blink mode is on
  assign led_next = regs.blink_en ? blink_gray : led_vec_t'(regs.led_data);

  // outputs are registered, so led trails a register write by one cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      led <= '0;
    end
    else
    begin
      led <= led_next;
    end
  end

  // ADC clock is a registered copy of the synchronized sclk
  // held low while routing is off; no gating on a real clock net
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      adc_sclk <= 1'b0;
    end
    else
    begin
      adc_sclk <= sclk_sync & regs.adc_route_en;
    end
  end

endmodule

//--- src/board_ctrl_top.sv
// board controller top: SPI receiver feeds the register bank,
// which feeds the LED and ADC clock driver
`timescale 1ns/1ps

module board_ctrl_top
  import board_ctrl_pkg::*;
#(
  // blink prescaler width, small values speed up simulation
  parameter int unsigned LOG2DELAY = 19
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     sclk,
  input  logic     cs_n,
  input  logic     mosi,
  output led_vec_t led,
  output logic     adc_sclk
);

  // receiver to bank
  wr_cmd_t    cmd;
  logic       wr_strobe;

  // synchronized sclk, reused by the driver
  logic       sclk_sync;

  // bank to driver
  ctrl_regs_t regs;

  spi_frame_receiver u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .cmd       (cmd),
    .wr_strobe (wr_strobe),
    .sclk_sync (sclk_sync)
  );

  ctrl_reg_bank u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .wr_strobe (wr_strobe),
    .regs      (regs)
  );

  board_io_driver #(
    .LOG2DELAY (LOG2DELAY)
  ) u_io (
    .clk       (clk),
    .rst_n     (rst_n),
    .regs      (regs),
    .sclk_sync (sclk_sync),
    .led       (led),
    .adc_sclk  (adc_sclk)
  );

endmodule

//--- tests/board_ctrl_tb.sv
// testbench for the SPI board controller top level
// sends SPI write frames and checks the LED and ADC clock outputs
`timescale 1ns/1ps

module board_ctrl_tb
  import board_ctrl_pkg::*;
;

  // about 18 frames of ~140 cycles, a 264 cycle blink window, plus margin
  localparam int TIMEOUT_CYCLES = 6000;
  // clk cycles per sclk phase
  localparam int HALF_BIT = 4;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     sclk;
  logic     cs_n;
  logic     mosi;
  led_vec_t led;
  logic     adc_sclk;

  integer    seed = 32'h0ce7_1e2a;
  int        cycle_cnt = 0;
  int        pass_cnt = 0;
  int        fail_cnt = 0;
  int        test_checks = 0;
  int        test_fails = 0;
  string     test_name;
  // last value written to the LED data register
  reg_data_t led_model;

  // toggle counters for sclk and adc_sclk, active while count_en is set
  logic count_en = 1'b0;
  logic sclk_prev = 1'b0;
  logic adc_prev = 1'b0;
  int   sclk_toggles = 0;
  int   adc_toggles = 0;

  board_ctrl_top #(
    .LOG2DELAY (3)
  ) uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .led      (led),
    .adc_sclk (adc_sclk)
  );

  always #2 clk = ~clk;

  // run limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("run timed out after %0d cycles in test %s", cycle_cnt, test_name);
      $display("Test failed");
      $finish;
    end
  end

  // sampled at the falling edge, away from the drive edge
  always @(negedge clk)
  begin
    if (count_en)
    begin
      if (sclk != sclk_prev)
        sclk_toggles = sclk_toggles + 1;
      if (adc_sclk != adc_prev)
        adc_toggles = adc_toggles + 1;
    end
    else
    begin
      sclk_toggles = 0;
      adc_toggles = 0;
    end
    sclk_prev = sclk;
    adc_prev = adc_sclk;
  end

  task automatic check_led(input string name, input led_vec_t exp, input led_vec_t act);
    assert (act === exp)
    begin
      pass_cnt++;
    end
    else
    begin
      $display("CHECK FAILED at %0t ns: %s expected 0x%02h, got 0x%02h",
               $time, name, exp, act);
      fail_cnt++;
    end
  endtask

  task automatic check_int(input string name, input int exp, input int act);
    assert (act == exp)
    begin
      pass_cnt++;
    end
    else
    begin
      $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      fail_cnt++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond)
    begin
      pass_cnt++;
    end
    else
    begin
      $display("error at %0t ns: %s", $time, msg);
      fail_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_checks = pass_cnt + fail_cnt;
    test_fails = fail_cnt;
  endtask

  task automatic end_test();
    $display("test %s done: %0d checks, %0d failing", test_name,
             pass_cnt + fail_cnt - test_checks, fail_cnt - test_fails);
  endtask

  // address, 4 don't-care bits, data
  function automatic logic [15:0] make_frame(input logic [3:0] addr, input reg_data_t data);
    return {addr, 4'h0, data};
  endfunction

  // mode 0 frame, nbits taken MSB first from the low end of bits
  // mosi changes while sclk is low, cs_n rises on return
  task automatic send_frame(input logic [31:0] bits, input int nbits);
    int i;
    repeat (HALF_BIT) @(posedge clk);
    cs_n <= 1'b0;
    repeat (HALF_BIT) @(posedge clk);
    for (i = nbits - 1; i >= 0; i--)
    begin
      mosi <= bits[i];
      repeat (HALF_BIT) @(posedge clk);
      sclk <= 1'b1;
      repeat (HALF_BIT) @(posedge clk);
      sclk <= 1'b0;
    end
    repeat (HALF_BIT) @(posedge clk);
    cs_n <= 1'b1;
    mosi <= 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input reg_data_t data);
    send_frame({16'h0, make_frame(addr, data)}, 16);
  endtask

  // allows up to max_cycles for the commit to reach the pins
  task automatic expect_led_within(input led_vec_t exp, input int max_cycles);
    int n;
    n = 0;
    while (n < max_cycles && led !== exp)
    begin
      @(negedge clk);
      n++;
    end
    check_led("led", exp, led);
  endtask

  // one check over the window, reporting the first wrong value
  task automatic expect_led_hold(input led_vec_t exp, input int cycles);
    led_vec_t seen;
    seen = exp;
    repeat (cycles)
    begin
      @(negedge clk);
      if (led !== exp && seen === exp)
        seen = led;
    end
    check_led("led", exp, seen);
  endtask

  initial
  begin
    logic [15:0] word16;
    logic [31:0] rnd;
    led_vec_t    prev;
    int          changes;
    rst_n <= 1'b0;
    sclk <= 1'b0;
    cs_n <= 1'b1;
    mosi <= 1'b0;
    led_model = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // sclk moves with cs_n high, nothing may reach the pins
    start_test("reset_state");
    @(negedge clk);
    check_led("led", 8'h00, led);
    check_int("adc_sclk", 0, int'(adc_sclk));
    count_en = 1'b1;
    repeat (10)
    begin
      repeat (HALF_BIT) @(posedge clk);
      sclk <= ~sclk;
    end
    repeat (8) @(negedge clk);
    check_int("adc_sclk toggles", 0, adc_toggles);
    check_led("led", 8'h00, led);
    count_en = 1'b0;
    end_test();

    start_test("static_led");
    repeat (8)
    begin
      rnd = $random(seed);
      led_model = rnd[7:0];
      write_reg(REG_LED_DATA, led_model);
      expect_led_within(led_model, 8);
    end
    end_test();

    start_test("malformed_frames");
    word16 = make_frame(REG_LED_DATA, ~led_model);
    // a short frame keeps the last bit of the previous frame as its top address bit
    // the unmapped frame leaves a 0 there so a committed 15 bit frame hits REG_LED_DATA
    write_reg(4'd5, {~led_model[7:1], 1'b0});
    expect_led_hold(led_model, 10);
    // 15 and 17 bit frames would change led if committed
    send_frame({17'h0, word16[15:1]}, 15);
    expect_led_hold(led_model, 10);
    send_frame({15'h0, 1'b1, word16}, 17);
    expect_led_hold(led_model, 10);
    end_test();

    start_test("blink_mode");
    write_reg(REG_LED_MODE, 8'h01);
    repeat (8) @(negedge clk);
    prev = led;
    changes = 0;
    // consecutive Gray codes differ in exactly one bit
    repeat (256)
    begin
      @(negedge clk);
      if (led !== prev)
      begin
        changes++;
        check_int("led bits flipped per step", 1, $countones(led ^ prev));
        prev = led;
      end
    end
    check_true(changes >= 16, "led did not keep changing in blink mode");
    write_reg(REG_LED_MODE, 8'h00);
    expect_led_within(led_model, 8);
    end_test();

    start_test("adc_route");
    write_reg(REG_ADC_ROUTE, 8'h01);
    repeat (8) @(negedge clk);
    count_en = 1'b1;
    write_reg(4'd5, 8'h3c);
    // adc_sclk trails sclk by the synchronizer and one register
    repeat (8) @(negedge clk);
    check_int("sclk toggles", 2 * FRAME_BITS, sclk_toggles);
    check_int("adc_sclk toggles", sclk_toggles, adc_toggles);
    count_en = 1'b0;
    write_reg(REG_ADC_ROUTE, 8'h00);
    repeat (8) @(negedge clk);
    check_int("adc_sclk", 0, int'(adc_sclk));
    count_en = 1'b1;
    write_reg(4'd5, 8'hc3);
    repeat (8) @(negedge clk);
    check_int("adc_sclk toggles", 0, adc_toggles);
    count_en = 1'b0;
    check_led("led", led_model, led);
    end_test();

    $display("checks passed %0d, checks failing %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
common/board_ctrl_pkg.sv
spi_slave/spi_frame_receiver.sv
src/ctrl_reg_bank.sv
src/board_io_driver.sv
src/board_ctrl_top.sv
tests/board_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f sim.f --top-module board_ctrl_tb \
  -Mdir obj_dir -o board_ctrl_sim || { echo "verilator build did not succeed"; exit 1; }
out=$(./obj_dir/board_ctrl_sim)
echo "$out"
echo "$out" | grep -q "Test completed successfully" && exit 0 || exit 1
